// ==== filelist.f ====
logic/rx_link_pkg.sv
logic/aligned_byte_if.sv
logic/frame_aligner.sv
logic/ack_decoder.sv
logic/frame_checker.sv
logic/rx_link.sv
test/rx_link_assert.sv
test/rx_link_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module rx_link_tb \
   -o rx_link_sim && obj_dir/rx_link_sim | tee sim.log
grep -qs '^\*\* PASS \*\*$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== test/rx_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_link_tb;

   logic               clk = 1'b0;
   logic               reset = 1'b1;
   logic               enable = 1'b0;
   rx_link_pkg::byte_t data_in = '0;
   logic               ack_pos;
   logic               ack_neg;
   logic               payload_valid;
   logic               frame_done;
   logic               frame_ok;
   rx_link_pkg::byte_t payload_data;
   rx_link_pkg::len_t  frame_len;

   logic [31:0]        rng = 32'h4fda_9977;
   bit                 bits[$];       // stream bits msb first.
   rx_link_pkg::byte_t sent[$];
   int                 item_size[$];  // bytes per item in sent.
   int                 exp_ack[$];
   int                 exp_pay[$];
   int                 exp_res[$];    // ok * 32 + length.
   int                 budget = 0;
   int                 value_errors = 0;
   int                 event_errors = 0;

   rx_link dut0 (.*);

   initial
   begin
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   // expected events from the sent items.
   function automatic void predict();
      int p;
      int n;
      int len;
      rx_link_pkg::byte_t sum;
      p = 0;
      foreach (item_size[i])
      begin
         n = item_size[i];
         len = (n > 1) ? int'(sent[p+1]) : 0;
         if (n == 1)
            exp_ack.push_back(sent[p]);
         else if (len >= 1 && len <= rx_link_pkg::MAX_PAYLOAD && n == len + 3)
         begin
            sum = '0;
            for (int j = 0; j < len; j++)
            begin
               exp_pay.push_back(sent[p+2+j]);
               sum += sent[p+2+j];
            end
            exp_res.push_back(int'(sum == sent[p+n-1]) * 32 + len);
         end
         p += n;  // short or illegal frames give nothing.
      end
   endfunction

   task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected)
      begin
         value_errors++;
         $display("** Error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic take(ref int q[$], input string what, output int v);
      v = -1;
      if (q.size() == 0)
      begin
         event_errors++;
         $display("unexpected %s at time %0t", what, $time);
      end
      else
         v = q.pop_front();
   endtask

   task automatic wait_cycles(int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic add_idle(int n);
      repeat (n) bits.push_back(1'b0);
   endtask

   task automatic add_byte(rx_link_pkg::byte_t b);
      sent.push_back(b);
      for (int i = 7; i >= 0; i--)
         bits.push_back(b[i]);
   endtask

   task automatic add_ack(rx_link_pkg::byte_t code);
      add_idle(16 + 8 * int'(next_rand() % 3));
      add_byte(code);
      item_size.push_back(1);
   endtask

   task automatic add_frame(int len, int n_pay, bit bad);
      int first;
      rx_link_pkg::byte_t sum;
      rx_link_pkg::byte_t b;
      add_idle(16 + 8 * int'(next_rand() % 3));
      first = sent.size();
      sum = '0;
      add_byte(rx_link_pkg::FRAME_HEADER);
      add_byte(rx_link_pkg::byte_t'(len));
      for (int j = 0; j < n_pay; j++)
      begin
         b = rx_link_pkg::byte_t'(next_rand());
         if (j == 1)
            b = rx_link_pkg::ACK_POS_CODE;
         else if (j == 3)
            b = rx_link_pkg::ACK_NEG_CODE;
         if (j == len - 1 && ((sum + b) & 8'h7f) == 8'h3f)
            b = b ^ 8'h40;  // checksum tail plus idle would read as a header.
         sum += b;
         add_byte(b);
      end
      if (n_pay == len)
         add_byte(bad ? sum + 8'h80 : sum);
      item_size.push_back(sent.size() - first);
   endtask

   task automatic run_stream(int offset, bit cut);
      int len;
      sent.delete();
      item_size.delete();
      bits.delete();
      add_idle(offset);
      add_ack(rx_link_pkg::ACK_POS_CODE);
      add_frame(16, 16, 1'b0);
      add_ack(rx_link_pkg::ACK_NEG_CODE);
      add_frame(5, 5, 1'b1);
      add_frame(20, 0, 1'b0);
      add_frame(1, 1, 1'b0);
      for (int i = 0; i < 6; i++)
      begin
         len = 1 + int'(next_rand() % 16);
         if (next_rand() % 3 == 0)
            add_ack((next_rand() % 2 == 0) ? rx_link_pkg::ACK_POS_CODE : rx_link_pkg::ACK_NEG_CODE);
         else
            add_frame(len, len, next_rand() % 4 == 0);
      end
      if (cut)
         add_frame(8, 2, 1'b0);  // enable drops before any payload leaves.
      else
         add_idle(64);
      while (bits.size() % 8 != 0)
         bits.push_back(1'b0);
      predict();
      budget += 40 * bits.size();
      enable = 1'b1;
      while (bits.size() > 0)
      begin
         for (int i = 7; i >= 0; i--)
            data_in[i] = bits.pop_front();
         wait_cycles(1);
      end
      enable = 1'b0;
      data_in = '0;
      wait_cycles(4);
   endtask

   // compare process.
   initial
   begin
      int v;
      forever
      begin
         @(negedge clk);
         if (ack_pos || ack_neg)
         begin
            take(exp_ack, "acknowledge", v);
            if (v >= 0)
            begin
               check("ack_pos", ack_pos, v == rx_link_pkg::ACK_POS_CODE);
               check("ack_neg", ack_neg, v == rx_link_pkg::ACK_NEG_CODE);
            end
         end
         if (payload_valid)
         begin
            take(exp_pay, "payload byte", v);
            if (v >= 0)
               check("payload_data", payload_data, v);
         end
         if (frame_done)
         begin
            take(exp_res, "frame result", v);
            if (v >= 0)
            begin
               check("frame_ok", frame_ok, v / 32);
               check("frame_len", frame_len, v % 32);
            end
         end
      end
   end

   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles <= budget + 1000)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the test did not end within %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      wait_cycles(16);
      reset = 1'b0;
      run_stream(0, 1'b1);
      run_stream(3, 1'b1);
      run_stream(7, 1'b0);
      if (exp_ack.size() + exp_pay.size() + exp_res.size() != 0)
      begin
         event_errors++;
         $display("missing events: %0d acknowledges, %0d payload bytes, %0d frame results",
                  exp_ack.size(), exp_pay.size(), exp_res.size());
      end
      $display("value errors %0d, event errors %0d", value_errors, event_errors);
      if (value_errors + event_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/rx_link_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_link_assert (
   input logic              clk,
   input logic              reset,
   input logic              locked,
   input logic              ack_pos,
   input logic              ack_neg,
   input logic              payload_valid,
   input logic              frame_done,
   input rx_link_pkg::len_t frame_len
);

   ack_exclusive: assert property (@(posedge clk) disable iff (reset) !(ack_pos && ack_neg))
      else $error("ack_pos and ack_neg high together");

   len_in_range: assert property (@(posedge clk) disable iff (reset)
      frame_done |-> (frame_len >= 5'd1 && frame_len <= rx_link_pkg::MAX_PAYLOAD))
      else $error("frame_len out of range with frame_done");

   // no acknowledge out of a frame body.
   quiet_when_locked: assert property (@(posedge clk) disable iff (reset)
      locked |=> !(ack_pos || ack_neg))
      else $error("acknowledge pulse after a locked cycle");

   reset_clears: assert property (@(posedge clk)
      reset |=> !(ack_pos || ack_neg || payload_valid || frame_done))
      else $error("outputs not cleared after reset");

endmodule

bind rx_link rx_link_assert assert0 (.*);

`default_nettype wire

// ==== logic/rx_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_link (
   input  logic               clk,
   input  logic               reset,
   input  logic               enable,
   input  rx_link_pkg::byte_t data_in,
   output logic               ack_pos,
   output logic               ack_neg,
   output logic               payload_valid,
   output logic               frame_done,
   output logic               frame_ok,
   output rx_link_pkg::byte_t payload_data,
   output rx_link_pkg::len_t  frame_len
);

   rx_link_pkg::window_t window;
   logic                 locked;

   aligned_byte_if frame_bus ();

   frame_aligner aligner0 (
      .clk     (clk),
      .reset   (reset),
      .enable  (enable),
      .data_in (data_in),
      .window  (window),
      .locked  (locked),
      .out     (frame_bus.source)
   );

   // shares the aligner window.
   ack_decoder ack0 (
      .clk     (clk),
      .reset   (reset),
      .enable  (enable),
      .locked  (locked),
      .window  (window),
      .ack_pos (ack_pos),
      .ack_neg (ack_neg)
   );

   frame_checker checker0 (
      .clk           (clk),
      .reset         (reset),
      .enable        (enable),
      .in            (frame_bus.sink),
      .payload_data  (payload_data),
      .payload_valid (payload_valid),
      .frame_done    (frame_done),
      .frame_ok      (frame_ok),
      .frame_len     (frame_len)
   );

endmodule

`default_nettype wire

// ==== logic/frame_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
   input  logic               clk,
   input  logic               reset,
   input  logic               enable,
   aligned_byte_if.sink       in,
   output rx_link_pkg::byte_t payload_data,
   output logic               payload_valid,
   output logic               frame_done,
   output logic               frame_ok,
   output rx_link_pkg::len_t  frame_len
);

   rx_link_pkg::byte_t sum;
   logic               is_payload;

   assign is_payload = in.valid && !in.first && !in.last;

   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         payload_valid <= 1'b0;
         frame_done    <= 1'b0;
         frame_ok      <= 1'b0;
         frame_len     <= '0;
      end
      else
      begin
         payload_valid <= is_payload;
         frame_done    <= in.valid && in.last;
         if (in.valid && in.last)
         begin
            frame_ok  <= (sum == in.data);  // held until next frame.
            frame_len <= in.len;
         end
      end
   end

   // running sum mod 256.
   always_ff @(posedge clk)
   begin
      if (in.valid && in.first)
      begin
         sum <= '0;
      end
      else if (is_payload)
      begin
         sum <= sum + in.data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (is_payload)
      begin
         payload_data <= in.data;
      end
   end

endmodule

`default_nettype wire

// ==== logic/ack_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ack_decoder (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 locked,
   input  rx_link_pkg::window_t window,
   output logic                 ack_pos,
   output logic                 ack_neg
);

   logic pos_hit;
   logic neg_hit;

   // any of the eight candidates.
   always_comb
   begin
      pos_hit = 1'b0;
      neg_hit = 1'b0;
      for (int s = 0; s < 8; s++)
      begin
         if (window[rx_link_pkg::WINDOW_W - 1 - s -: 8] == rx_link_pkg::ACK_POS_CODE)
         begin
            pos_hit = 1'b1;
         end
         if (window[rx_link_pkg::WINDOW_W - 1 - s -: 8] == rx_link_pkg::ACK_NEG_CODE)
         begin
            neg_hit = 1'b1;
         end
      end
   end

   // quiet while a frame is being read.
   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         ack_pos <= 1'b0;
         ack_neg <= 1'b0;
      end
      else
      begin
         ack_pos <= pos_hit && !locked;
         ack_neg <= neg_hit && !locked;
      end
   end

endmodule

`default_nettype wire

// ==== logic/frame_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_aligner (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  rx_link_pkg::byte_t   data_in,
   output rx_link_pkg::window_t window,
   output logic                 locked,
   aligned_byte_if.source       out
);

   rx_link_pkg::byte_t        hist1;
   rx_link_pkg::byte_t        hist2;
   rx_link_pkg::byte_t        hist3;
   rx_link_pkg::align_state_t state;
   rx_link_pkg::shift_t       lock_shift;
   rx_link_pkg::len_t         remaining;
   rx_link_pkg::shift_t       hdr_shift;
   logic                      hdr_hit;
   rx_link_pkg::byte_t        cand;
   logic                      len_ok;

   // chunk history, newest in hist1.
   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         hist1 <= '0;
         hist2 <= '0;
         hist3 <= '0;
      end
      else
      begin
         hist1 <= data_in;
         hist2 <= hist1;
         hist3 <= hist2;
      end
   end

   assign window = {hist3, hist2};
   assign locked = (state != rx_link_pkg::HUNT);

   // scan high to low so the lowest offset is kept.
   always_comb
   begin
      hdr_hit   = 1'b0;
      hdr_shift = '0;
      for (int s = 7; s >= 0; s--)
      begin
         if (window[rx_link_pkg::WINDOW_W - 1 - s -: 8] == rx_link_pkg::FRAME_HEADER)
         begin
            hdr_hit   = 1'b1;
            hdr_shift = rx_link_pkg::shift_t'(s);
         end
      end
   end

   assign cand   = window[rx_link_pkg::WINDOW_W - 1 - int'(lock_shift) -: 8];  // locked byte.
   assign len_ok = (cand != '0) && (cand <= rx_link_pkg::MAX_PAYLOAD);

   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         state      <= rx_link_pkg::HUNT;
         lock_shift <= '0;
         remaining  <= '0;
         out.valid  <= 1'b0;
      end
      else
      begin
         out.valid <= 1'b0;
         case (state)
            rx_link_pkg::HUNT:
            begin
               if (hdr_hit)
               begin
                  lock_shift <= hdr_shift;
                  state      <= rx_link_pkg::LENGTH;
               end
            end
            rx_link_pkg::LENGTH:
            begin
               if (len_ok)
               begin
                  out.valid <= 1'b1;
                  remaining <= rx_link_pkg::len_t'(cand);
                  state     <= rx_link_pkg::PAYLOAD;
               end
               else
               begin
                  state <= rx_link_pkg::HUNT;  // bad length, drop it.
               end
            end
            rx_link_pkg::PAYLOAD:
            begin
               out.valid <= 1'b1;
               remaining <= remaining - 1'b1;
               if (remaining == 5'd1)
               begin
                  state <= rx_link_pkg::CHECK;
               end
            end
            default:
            begin
               out.valid <= 1'b1;  // checksum byte.
               state     <= rx_link_pkg::HUNT;
            end
         endcase
      end
   end

   // byte fields, qualified by out.valid.
   always_ff @(posedge clk)
   begin
      out.data  <= cand;
      out.first <= (state == rx_link_pkg::LENGTH);
      out.last  <= (state == rx_link_pkg::CHECK);
      if (state == rx_link_pkg::LENGTH)
      begin
         out.len <= rx_link_pkg::len_t'(cand);
      end
   end

endmodule

`default_nettype wire

// ==== logic/aligned_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface aligned_byte_if;

   rx_link_pkg::byte_t data;
   logic               valid;  // one strobe per byte.
   logic               first;  // length byte.
   logic               last;   // checksum byte.
   rx_link_pkg::len_t  len;

   modport source (
      output data,
      output valid,
      output first,
      output last,
      output len
   );

   modport sink (
      input data,
      input valid,
      input first,
      input last,
      input len
   );

endinterface

`default_nettype wire

// ==== logic/rx_link_pkg.sv ====
`default_nettype none

package rx_link_pkg;

   localparam int BYTE_W   = 8;
   localparam int WINDOW_W = 2 * BYTE_W;
   localparam int SHIFT_W  = 3;
   localparam int LEN_W    = 5;

   typedef logic [BYTE_W-1:0]   byte_t;
   typedef logic [WINDOW_W-1:0] window_t;  // older chunk in the high half.
   typedef logic [SHIFT_W-1:0]  shift_t;
   typedef logic [LEN_W-1:0]    len_t;

   // acknowledge codes.
   localparam byte_t ACK_POS_CODE = 8'h5f;
   localparam byte_t ACK_NEG_CODE = 8'haf;

   localparam byte_t FRAME_HEADER = 8'h7e;

   // largest legal length byte.
   localparam len_t MAX_PAYLOAD = 5'd16;

   typedef enum logic [1:0]
   {
      HUNT,
      LENGTH,
      PAYLOAD,
      CHECK
   } align_state_t;

endpackage

`default_nettype wire
